//--- design/nand_pkg.sv
`default_nettype none

package nand_pkg;

    // command set, read and page program only
    localparam logic [7:0] cmd_read_lo = 8'h00;  // lower half-page
    localparam logic [7:0] cmd_read_hi = 8'h01;  // upper half-page
    localparam logic [7:0] cmd_prog    = 8'h80;
    localparam logic [7:0] cmd_prog_go = 8'h10;

    // what a port does in one two-clock bus cycle
    typedef enum logic [2:0] {
        cyc_idle,
        cyc_cmd,    // CLE high, WE strobe
        cyc_addr,   // ALE high, WE strobe
        cyc_wdata,  // WE strobe only
        cyc_rdata   // RE strobe only
    } cycle_kind_t;

    typedef struct packed {
        cycle_kind_t kind;
        logic [7:0]  wbyte;
    } bus_req_t;

    // pins toward the device
    typedef struct packed {
        logic       cle;
        logic       ale;
        logic       ren;     // active low
        logic       wen;     // active low
        logic       io_oe;
        logic [7:0] io_out;
    } nand_out_t;

    typedef struct packed {
        logic       rb;      // low while busy
        logic [7:0] io_in;
    } nand_in_t;

endpackage

`default_nettype wire

//--- design/copy_pkg.sv
`default_nettype none

package copy_pkg;

    localparam int chunk_bytes = 16;
    localparam int addr_bits   = 18;

    typedef logic [$clog2(chunk_bytes)-1:0] buf_idx_t;

    // enough for the full device, 16384 chunks
    typedef logic [14:0] chunk_cnt_t;

    // field view of the flash address
    // col -> addr byte 1, page -> byte 2, blk -> byte 3
    typedef struct packed {
        logic       blk;
        logic [7:0] page;
        logic       half;    // picks 00h or 01h read
        logic [7:0] col;
    } flash_addr_t;

    // flat for stepping, fields for the address cycles
    typedef union packed {
        logic [addr_bits-1:0] flat;
        flash_addr_t          f;
    } flash_addr_u;

endpackage

`default_nettype wire

//--- design/cycle_timer.sv
`timescale 1ns/1ps
`default_nettype none

module cycle_timer (
    input  logic               clk,
    input  logic               rst,
    input  logic               burst_start,
    input  logic [4:0]         burst_len,
    output logic               phase,
    output copy_pkg::buf_idx_t cyc_idx,
    output logic               cyc_last,
    output logic               busy
);
    import copy_pkg::*;

    logic     run;
    buf_idx_t last_idx;

    assign busy     = run;
    assign cyc_last = run && phase && (cyc_idx == last_idx);

    // the burst_start clock itself is phase 0 of cycle 0,
    // so phase and cyc_idx rest at zero between bursts
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run      <= 1'b0;
            phase    <= 1'b0;
            cyc_idx  <= '0;
            last_idx <= '0;
        end else if (burst_start) begin
            run      <= 1'b1;
            phase    <= 1'b1;
            last_idx <= buf_idx_t'(burst_len - 5'd1);
        end else if (run) begin
            phase <= ~phase;
            if (phase) begin
                if (cyc_idx == last_idx) begin
                    run     <= 1'b0;
                    cyc_idx <= '0;
                end else begin
                    cyc_idx <= cyc_idx + 1'b1;
                end
            end
        end
    end

    // fsm chains bursts only after the previous one has ended
    assert property (@(posedge clk) disable iff (rst) burst_start |-> !busy);

    assert property (@(posedge clk) disable iff (rst)
        burst_start |-> (burst_len inside {[5'd1:5'd16]}));

endmodule

`default_nettype wire

//--- design/copy_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module copy_fsm #(
    parameter int NUM_CHUNKS = 16384
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               rb_a,
    input  logic               rb_b,
    input  logic [7:0]         rd_buf_byte,
    input  copy_pkg::buf_idx_t cyc_idx,
    input  logic               cyc_last,
    output logic               burst_start,
    output logic [4:0]         burst_len,
    output nand_pkg::bus_req_t req_a,
    output nand_pkg::bus_req_t req_b,
    output logic               done
);
    import nand_pkg::*;
    import copy_pkg::*;

    typedef enum logic [3:0] {
        idle,
        a_wait,
        a_cmd,
        a_addr,
        a_busy,  // array read in progress
        a_read,
        b_wait,
        b_cmd,
        b_addr,
        b_data,
        b_go,
        b_busy,  // page program in progress
        finish
    } state_t;

    state_t      state;
    state_t      state_nxt;
    flash_addr_u addr;
    chunk_cnt_t  chunk_cnt;
    logic        start_nxt;
    logic [4:0]  len_nxt;
    logic        last_chunk;
    logic [7:0]  addr_byte;
    logic [7:0]  wbyte;

    assign last_chunk = (chunk_cnt == chunk_cnt_t'(NUM_CHUNKS - 1));
    assign done       = (state == finish);

    // burst_start is registered, so it is high in the first clock of a burst state
    always_comb begin
        state_nxt = state;
        start_nxt = 1'b0;
        len_nxt   = burst_len;
        case (state)
            idle: state_nxt = a_wait;
            a_wait: if (rb_a) begin
                state_nxt = a_cmd;
                start_nxt = 1'b1;
                len_nxt   = 5'd1;
            end
            a_cmd: if (cyc_last) begin
                state_nxt = a_addr;
                start_nxt = 1'b1;
                len_nxt   = 5'd3;
            end
            a_addr: if (cyc_last) state_nxt = a_busy;
            a_busy: if (rb_a) begin
                state_nxt = a_read;
                start_nxt = 1'b1;
                len_nxt   = 5'(chunk_bytes);
            end
            a_read: if (cyc_last) state_nxt = b_wait;
            b_wait: if (rb_b) begin
                state_nxt = b_cmd;
                start_nxt = 1'b1;
                len_nxt   = 5'd1;
            end
            b_cmd: if (cyc_last) begin
                state_nxt = b_addr;
                start_nxt = 1'b1;
                len_nxt   = 5'd3;
            end
            b_addr: if (cyc_last) begin
                state_nxt = b_data;
                start_nxt = 1'b1;
                len_nxt   = 5'(chunk_bytes);
            end
            b_data: if (cyc_last) begin
                state_nxt = b_go;
                start_nxt = 1'b1;
                len_nxt   = 5'd1;
            end
            b_go: if (cyc_last) state_nxt = b_busy;
            b_busy: if (rb_b) state_nxt = last_chunk ? finish : a_wait;
            default: state_nxt = state;  // finish holds until reset
        endcase
    end

    always_comb begin
        case (cyc_idx)
            4'd0:    addr_byte = addr.f.col;
            4'd1:    addr_byte = addr.f.page;
            default: addr_byte = {7'd0, addr.f.blk};
        endcase
    end

    always_comb begin
        case (state)
            a_cmd:          wbyte = addr.f.half ? cmd_read_hi : cmd_read_lo;
            b_cmd:          wbyte = cmd_prog;
            b_go:           wbyte = cmd_prog_go;
            a_addr, b_addr: wbyte = addr_byte;
            b_data:         wbyte = rd_buf_byte;
            default:        wbyte = 8'h00;
        endcase
    end

    always_comb begin
        req_a = '{kind: cyc_idle, wbyte: 8'h00};
        req_b = '{kind: cyc_idle, wbyte: 8'h00};
        case (state)
            a_cmd:       req_a = '{kind: cyc_cmd, wbyte: wbyte};
            a_addr:      req_a = '{kind: cyc_addr, wbyte: wbyte};
            a_read:      req_a = '{kind: cyc_rdata, wbyte: 8'h00};
            b_cmd, b_go: req_b = '{kind: cyc_cmd, wbyte: wbyte};
            b_addr:      req_b = '{kind: cyc_addr, wbyte: wbyte};
            b_data:      req_b = '{kind: cyc_wdata, wbyte: wbyte};
            default:     ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= idle;
            burst_start <= 1'b0;
            burst_len   <= 5'd0;
            addr        <= '0;
            chunk_cnt   <= '0;
        end else begin
            state       <= state_nxt;
            burst_start <= start_nxt;
            burst_len   <= len_nxt;
            if (state == b_busy && rb_b) begin  // chunk programmed
                addr.flat <= addr.flat + addr_bits'(chunk_bytes);
                chunk_cnt <= chunk_cnt + 1'b1;
            end
        end
    end

    // timer is only kicked when a burst state is entered
    assert property (@(posedge clk) disable iff (rst)
        (state inside {a_wait, a_busy, b_wait, b_busy}) |-> !burst_start);

endmodule

`default_nettype wire

//--- design/nand_port.sv
`timescale 1ns/1ps
`default_nettype none

module nand_port (
    input  logic                clk,
    input  logic                rst,
    input  nand_pkg::bus_req_t  req,
    input  logic                phase,
    input  nand_pkg::nand_in_t  pins_in,
    output nand_pkg::nand_out_t pins_out,
    output logic                rb,
    output logic                rd_valid,
    output logic [7:0]          rd_byte
);
    import nand_pkg::*;

    logic is_write;
    logic is_read;

    assign is_write = (req.kind inside {cyc_cmd, cyc_addr, cyc_wdata});
    assign is_read  = (req.kind == cyc_rdata);

    // pins lag the request by one clock:
    // strobe is low in the phase-1 clock and rises at its end
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pins_out <= '{cle: 1'b0, ale: 1'b0, ren: 1'b1, wen: 1'b1,
                          io_oe: 1'b0, io_out: 8'h00};
        end else begin
            pins_out.cle    <= (req.kind == cyc_cmd);
            pins_out.ale    <= (req.kind == cyc_addr);
            pins_out.wen    <= ~(is_write && !phase);
            pins_out.ren    <= ~(is_read && !phase);
            pins_out.io_oe  <= is_write;
            pins_out.io_out <= req.wbyte;  // held across the WE rise
        end
    end

    assign rb = pins_in.rb;

    // device drives data while RE is low, sampled on the RE rising edge
    assign rd_valid = is_read && phase;
    assign rd_byte  = pins_in.io_in;

    assert property (@(posedge clk) disable iff (rst)
        !(pins_out.cle && pins_out.ale));

endmodule

`default_nettype wire

//--- design/chunk_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module chunk_buffer (
    input  logic               clk,
    input  logic               wr_en,
    input  copy_pkg::buf_idx_t wr_idx,
    input  copy_pkg::buf_idx_t rd_idx,
    input  logic [7:0]         wr_byte,
    output logic [7:0]         rd_byte
);
    import copy_pkg::*;

    // one chunk, filled from A then drained to B
    logic [7:0] mem [chunk_bytes];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_byte;
        end
    end

    assign rd_byte = mem[rd_idx];  // same-cycle read for the B data cycles

endmodule

`default_nettype wire

//--- design/nand_copy_top.sv
`timescale 1ns/1ps
`default_nettype none

module nand_copy_top #(
    parameter int NUM_CHUNKS = 16384
) (
    input  logic                clk,
    input  logic                rst,
    input  nand_pkg::nand_in_t  flash_a_in,
    input  nand_pkg::nand_in_t  flash_b_in,
    output nand_pkg::nand_out_t flash_a_out,
    output nand_pkg::nand_out_t flash_b_out,
    output logic                done
);
    import nand_pkg::*;
    import copy_pkg::*;

    bus_req_t   req_a;
    bus_req_t   req_b;
    logic       burst_start;
    logic [4:0] burst_len;
    logic       phase;
    buf_idx_t   cyc_idx;
    logic       cyc_last;
    logic       rb_a;
    logic       rb_b;
    logic       rd_valid;
    logic [7:0] rd_byte;
    logic [7:0] buf_byte;

    copy_fsm #(
        .NUM_CHUNKS(NUM_CHUNKS)
    ) i_fsm (
        .clk(clk),
        .rst(rst),
        .rb_a(rb_a),
        .rb_b(rb_b),
        .rd_buf_byte(buf_byte),
        .cyc_idx(cyc_idx),
        .cyc_last(cyc_last),
        .burst_start(burst_start),
        .burst_len(burst_len),
        .req_a(req_a),
        .req_b(req_b),
        .done(done)
    );

    cycle_timer i_timer (
        .clk(clk),
        .rst(rst),
        .burst_start(burst_start),
        .burst_len(burst_len),
        .phase(phase),
        .cyc_idx(cyc_idx),
        .cyc_last(cyc_last),
        .busy()
    );

    // source side
    nand_port i_port_a (
        .clk(clk),
        .rst(rst),
        .req(req_a),
        .phase(phase),
        .pins_in(flash_a_in),
        .pins_out(flash_a_out),
        .rb(rb_a),
        .rd_valid(rd_valid),
        .rd_byte(rd_byte)
    );

    // sink side, never reads
    nand_port i_port_b (
        .clk(clk),
        .rst(rst),
        .req(req_b),
        .phase(phase),
        .pins_in(flash_b_in),
        .pins_out(flash_b_out),
        .rb(rb_b),
        .rd_valid(),
        .rd_byte()
    );

    chunk_buffer i_buf (
        .clk(clk),
        .wr_en(rd_valid),
        .wr_idx(cyc_idx),
        .rd_idx(cyc_idx),
        .wr_byte(rd_byte),
        .rd_byte(buf_byte)
    );

endmodule

`default_nettype wire

//--- tb/nand_flash_model.sv
`timescale 1ns/1ps
`default_nettype none

module nand_flash_model #(
    parameter string       NAME = "flash",
    parameter logic [31:0] SEED = 32'h5a5d
) (
    input  logic                clk,
    input  logic                rst,
    input  nand_pkg::nand_out_t pins,
    output nand_pkg::nand_in_t  resp
);
    import nand_pkg::*;

    logic [7:0]  cmd_log[$];   // every command byte in order
    logic [23:0] addr_log[$];  // {byte 3, byte 2, byte 1}
    logic [7:0]  data_log[$];  // programmed bytes in order
    int          strobes;
    int          violations;
    int          prog_cmds;

    logic [23:0] addr_sr;
    int          addr_cnt;
    logic        reading;
    logic        half;
    logic        start_busy;
    logic [17:0] rd_addr;
    int          busy_left;
    integer      seed;

    // array content over the full address with the half bit
    function automatic logic [7:0] stored_byte(input logic [17:0] a);
        logic [31:0] v;
        v = 32'(a) * 32'd7 + 32'h3c;
        return v[7:0];
    endfunction

    initial begin
        seed       = SEED;
        strobes    = 0;
        violations = 0;
        prog_cmds  = 0;
        addr_sr    = '0;
        addr_cnt   = 3;
        reading    = 1'b0;
        half       = 1'b0;
        rd_addr    = '0;
        busy_left  = 0;
        resp       = '{rb: 1'b1, io_in: 8'h00};
    end

    // strobes are low for exactly one clock so each bus cycle is seen once
    always @(posedge clk) begin
        start_busy = 1'b0;
        if (!rst && (!pins.wen || !pins.ren)) begin
            strobes++;
            if (!resp.rb) begin
                violations++;
                $display("%0t ns: %s got a bus cycle while busy", $time, NAME);
            end
            // controller drives IO only under a write strobe
            if (pins.io_oe != !pins.wen) begin
                violations++;
                $display("%0t ns: %s saw IO enable %b with WE %b and RE %b", $time, NAME,
                         pins.io_oe, pins.wen, pins.ren);
            end
        end
        if (!rst && !pins.wen) begin
            if (pins.cle) begin
                cmd_log.push_back(pins.io_out);
                addr_cnt = 0;
                case (pins.io_out)
                    8'h00, 8'h01: begin
                        reading = 1'b1;
                        half    = pins.io_out[0];
                    end
                    8'h80: begin
                        reading = 1'b0;
                        prog_cmds++;
                    end
                    8'h10: start_busy = 1'b1;  // page program
                    default: begin
                        violations++;
                        $display("%0t ns: %s got unknown command %h", $time, NAME, pins.io_out);
                    end
                endcase
            end else if (pins.ale && addr_cnt < 3) begin
                addr_sr = {pins.io_out, addr_sr[23:8]};
                addr_cnt++;
                if (addr_cnt == 3) begin
                    addr_log.push_back(addr_sr);
                    if (reading) begin
                        rd_addr    = {addr_sr[16], addr_sr[15:8], half, addr_sr[7:0]};
                        start_busy = 1'b1;  // array read
                    end
                end
            end else if (!pins.ale && !pins.cle) begin
                data_log.push_back(pins.io_out);
            end
        end
        if (!rst && !pins.ren) begin
            rd_addr = rd_addr + 18'd1;
        end
        #1;
        if (start_busy) begin
            busy_left = 1 + int'($unsigned($random(seed)) % 8);
            resp.rb   = 1'b0;
        end else if (busy_left > 0) begin
            busy_left--;
            if (busy_left == 0) resp.rb = 1'b1;
        end
        resp.io_in = stored_byte(rd_addr);
    end

endmodule

`default_nettype wire

//--- tb/tb_nand_copy.sv
`timescale 1ns/1ps
`default_nettype none

module tb_nand_copy;
    import nand_pkg::*;

    localparam int num_chunks     = 40;
    localparam int chunk_len      = 16;
    localparam int timeout_cycles = num_chunks * 150 + 200;

    typedef struct packed {
        logic [23:0] addr_bytes;  // {blk, page, col}
        logic [7:0]  read_cmd;
        logic [7:0]  first_byte;
    } chunk_row_t;

    logic      clk;
    logic      rst;
    logic      done;
    nand_in_t  a_in;
    nand_in_t  b_in;
    nand_out_t a_out;
    nand_out_t b_out;

    chunk_row_t rows[$];
    int         errors;
    int         cycle_cnt;
    int         strobes_at_done;

    nand_copy_top #(
        .NUM_CHUNKS(num_chunks)
    ) i_dut (
        .clk(clk),
        .rst(rst),
        .flash_a_in(a_in),
        .flash_b_in(b_in),
        .flash_a_out(a_out),
        .flash_b_out(b_out),
        .done(done)
    );

    nand_flash_model #(.NAME("source flash"), .SEED(32'h5a5d)) i_src (
        .clk(clk), .rst(rst), .pins(a_out), .resp(a_in)
    );

    nand_flash_model #(.NAME("sink flash"), .SEED(32'h5a5d)) i_sink (
        .clk(clk), .rst(rst), .pins(b_out), .resp(b_in)
    );

    function automatic logic [7:0] expected_byte(input int a);
        int v;
        v = a * 7 + 'h3c;
        return v[7:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            errors++;
            $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
        end
    endtask

    task automatic verify_idle_pins(input string ch, input nand_out_t p);
        check_value({ch, ".wen"}, 32'(p.wen), 32'd1);
        check_value({ch, ".ren"}, 32'(p.ren), 32'd1);
        check_value({ch, ".cle"}, 32'(p.cle), 32'd0);
        check_value({ch, ".ale"}, 32'(p.ale), 32'd0);
        check_value({ch, ".io_oe"}, 32'(p.io_oe), 32'd0);
    endtask

    // one row per chunk with the address stepping by 16
    task automatic build_table();
        int k;
        int a;
        chunk_row_t row;
        for (k = 0; k < num_chunks; k++) begin
            a              = k * chunk_len;
            row.addr_bytes = {8'((a >> 17) & 1), 8'(a >> 9), 8'(a)};
            row.read_cmd   = ((k / 16) % 2 == 1) ? 8'h01 : 8'h00;
            row.first_byte = expected_byte(a);
            rows.push_back(row);
        end
    endtask

    task automatic compare_logs();
        int k;
        int i;
        int n;
        logic [7:0] exp;
        check_value("source command count", 32'(i_src.cmd_log.size()), 32'(num_chunks));
        check_value("source address count", 32'(i_src.addr_log.size()), 32'(num_chunks));
        check_value("sink command count", 32'(i_sink.cmd_log.size()), 32'(2 * num_chunks));
        check_value("sink address count", 32'(i_sink.addr_log.size()), 32'(num_chunks));
        check_value("sink data count", 32'(i_sink.data_log.size()),
                    32'(num_chunks * chunk_len));
        for (k = 0; k < num_chunks; k++) begin
            check_value($sformatf("source command %0d", k), 32'(i_src.cmd_log[k]),
                        32'(rows[k].read_cmd));
            check_value($sformatf("source address %0d", k), 32'(i_src.addr_log[k]),
                        32'(rows[k].addr_bytes));
            check_value($sformatf("sink command %0d", 2 * k), 32'(i_sink.cmd_log[2 * k]),
                        32'h80);
            check_value($sformatf("sink command %0d", 2 * k + 1),
                        32'(i_sink.cmd_log[2 * k + 1]), 32'h10);
            check_value($sformatf("sink address %0d", k), 32'(i_sink.addr_log[k]),
                        32'(rows[k].addr_bytes));
            for (i = 0; i < chunk_len; i++) begin
                n   = k * chunk_len + i;
                exp = (i == 0) ? rows[k].first_byte : expected_byte(n);
                check_value($sformatf("sink data byte %0d", n), 32'(i_sink.data_log[n]),
                            32'(exp));
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the copy did not finish within %0d cycles", timeout_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        errors = 0;
        rst    = 1'b1;
        build_table();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        verify_idle_pins("flash_a_out", a_out);  // no posedge since release yet
        verify_idle_pins("flash_b_out", b_out);
        check_value("done", 32'(done), 32'd0);

        while (!done) @(negedge clk);
        check_value("sink program commands at done", 32'(i_sink.prog_cmds), 32'(num_chunks));
        strobes_at_done = i_src.strobes + i_sink.strobes;
        repeat (100) begin
            @(negedge clk);
            check_value("done", 32'(done), 32'd1);
        end
        check_value("strobes after done", 32'(i_src.strobes + i_sink.strobes),
                    32'(strobes_at_done));
        compare_logs();
        assert (i_src.violations == 0 && i_sink.violations == 0) else begin
            errors++;
            $display("a flash model saw a busy, IO enable or command violation");
        end

        $display("%0d check errors, %0d source violations, %0d sink violations",
                 errors, i_src.violations, i_sink.violations);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
design/nand_pkg.sv
design/copy_pkg.sv
design/cycle_timer.sv
design/copy_fsm.sv
design/nand_port.sv
design/chunk_buffer.sv
design/nand_copy_top.sv
tb/nand_flash_model.sv
tb/tb_nand_copy.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_nand_copy -f list.f

output=$(./obj_dir/Vtb_nand_copy)
echo "$output"

if grep -q "TESTBENCH PASSED" <<< "$output"; then
    exit 0
fi
exit 1
